// ==== source/memctrl_params.svh ====
// Cache controller geometry: ways, sets, tag width and line layout
`ifndef MEMCTRL_PARAMS_SVH
`define MEMCTRL_PARAMS_SVH

// Associativity
`define MEMCTRL_WAYS 4

// Sets per way, one directory entry each
`define MEMCTRL_SETS 16

// Tag bits stored in every directory entry
`define MEMCTRL_TAG_W 8

// Data word, stored as one RAM per byte lane
`define MEMCTRL_WORD_W 32

// Words in a cache line
`define MEMCTRL_LINE_WORDS 4

`endif

// ==== source/memctrl_pkg.sv ====
// Cache controller package: directory entry, request and result types
`default_nettype none

`include "memctrl_params.svh"

package memctrl_pkg;

    typedef logic [$clog2(`MEMCTRL_SETS)-1:0]       set_t;
    typedef logic [`MEMCTRL_TAG_W-1:0]              tag_t;
    typedef logic [`MEMCTRL_WAYS-1:0]               way_vec_t;
    typedef logic [$clog2(`MEMCTRL_LINE_WORDS)-1:0] word_idx_t;
    typedef logic [`MEMCTRL_WORD_W-1:0]             data_word_t;
    typedef logic [`MEMCTRL_WORD_W/8-1:0]           byte_en_t;

    typedef struct packed {
        logic valid;
        logic dirty;
        tag_t tag;
    } dir_entry_t;

    typedef enum logic [1:0] {
        DIR_NONE,
        DIR_LOOKUP,
        DIR_REFILL,
        DIR_INVAL
    } dir_op_e;

    // Lookups carry the tag to compare in entry.tag
    typedef struct packed {
        dir_op_e    op;
        set_t       set;
        way_vec_t   way;
        dir_entry_t entry;
    } dir_req_t;

    typedef enum logic [1:0] {
        DATA_NONE,
        DATA_READ,
        DATA_WRITE,
        DATA_REFILL
    } data_op_e;

    typedef struct packed {
        data_op_e   op;
        set_t       set;
        word_idx_t  word;
        way_vec_t   way;
        data_word_t wdata;
        byte_en_t   be;
    } data_req_t;

    typedef struct packed {
        way_vec_t way;
        tag_t     tag;
        logic     dirty;
    } dir_hit_t;

    typedef struct packed {
        way_vec_t way;
        logic     valid;
        logic     dirty;
        tag_t     tag;
    } dir_victim_t;

endpackage

`default_nettype wire

// ==== source/memctrl_sram.sv ====
// Single-port synchronous RAM with registered read and a generic payload type
`timescale 1ns/1ps
`default_nettype none

module memctrl_sram #(
    parameter type         payload_t = logic,
    parameter int unsigned DEPTH     = 16
) (
    input  logic                     clk_i,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  payload_t                 wdata_i,
    output payload_t                 rdata_o
);

    payload_t mem_q [DEPTH];

    // Read data holds while the RAM is idle or written
    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem_q[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/memctrl_dir.sv ====
// Cache directory: command mux, init sequencer, per-way tag RAMs and lookup registers
`timescale 1ns/1ps
`default_nettype none

`include "memctrl_params.svh"

module memctrl_dir (
    input  logic                                      clk_i,
    input  logic                                      rst_ni,
    input  memctrl_pkg::dir_req_t                     dir_req_i,
    output logic                                      ready_o,
    output memctrl_pkg::dir_entry_t [`MEMCTRL_WAYS-1:0] rentries_o,
    output memctrl_pkg::tag_t                         lookup_tag_o,
    output memctrl_pkg::set_t                         lookup_set_o
);
    import memctrl_pkg::*;

    logic       init_done_q;
    set_t       init_set_q;

    set_t       dir_addr;
    way_vec_t   dir_cs;
    way_vec_t   dir_we;
    dir_entry_t dir_wentry;

    // Clear one set per cycle in all ways, then report ready
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_done_q <= 1'b0;
            init_set_q  <= '0;
        end else if (!init_done_q) begin
            init_set_q <= init_set_q + 1'b1;
            if (init_set_q == set_t'(`MEMCTRL_SETS - 1)) begin
                init_done_q <= 1'b1;
            end
        end
    end

    assign ready_o = init_done_q;

    always_comb begin
        dir_addr   = dir_req_i.set;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '0;

        if (!init_done_q) begin
            dir_addr = init_set_q;
            dir_cs   = '1;
            dir_we   = '1;
        end else begin
            case (dir_req_i.op)
                // Read every way of the set
                DIR_LOOKUP: begin
                    dir_cs = '1;
                end
                DIR_REFILL: begin
                    dir_cs     = dir_req_i.way;
                    dir_we     = dir_req_i.way;
                    dir_wentry = dir_req_i.entry;
                end
                // Zero entry clears valid and dirty
                DIR_INVAL: begin
                    dir_cs = dir_req_i.way;
                    dir_we = dir_req_i.way;
                end
                default: begin
                end
            endcase
        end
    end

    for (genvar w = 0; w < `MEMCTRL_WAYS; w++) begin : g_way
        memctrl_sram #(
            .payload_t (dir_entry_t),
            .DEPTH     (`MEMCTRL_SETS)
        ) u_dir_ram (
            .clk_i,
            .cs_i      (dir_cs[w]),
            .we_i      (dir_we[w]),
            .addr_i    (dir_addr),
            .wdata_i   (dir_wentry),
            .rdata_o   (rentries_o[w])
        );
    end

    // Set and tag line up with the RAM output one cycle later
    always_ff @(posedge clk_i) begin
        if (init_done_q && dir_req_i.op == DIR_LOOKUP) begin
            lookup_set_o <= dir_req_i.set;
            lookup_tag_o <= dir_req_i.entry.tag;
        end
    end

    a_no_cmd_before_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_o |-> dir_req_i.op == DIR_NONE)
        else $error("memctrl_dir: directory command during init");

    a_write_way_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dir_req_i.op inside {DIR_REFILL, DIR_INVAL} |-> $onehot(dir_req_i.way))
        else $error("memctrl_dir: refill or inval way is not one-hot");

endmodule

`default_nettype wire

// ==== source/memctrl_hit.sv ====
// Directory hit logic: tag compare plus hit and victim field extraction
`timescale 1ns/1ps
`default_nettype none

`include "memctrl_params.svh"

module memctrl_hit (
    input  memctrl_pkg::dir_entry_t [`MEMCTRL_WAYS-1:0] rentries_i,
    input  memctrl_pkg::tag_t                         lookup_tag_i,
    input  memctrl_pkg::way_vec_t                     victim_way_i,
    output memctrl_pkg::dir_hit_t                     dir_hit_o,
    output memctrl_pkg::dir_victim_t                  dir_victim_o
);
    import memctrl_pkg::*;

    way_vec_t hit_way;

    always_comb begin
        dir_hit_o    = '0;
        dir_victim_o = '0;

        for (int w = 0; w < `MEMCTRL_WAYS; w++) begin
            hit_way[w] = rentries_i[w].valid && (rentries_i[w].tag == lookup_tag_i);
        end

        dir_hit_o.way    = hit_way;
        dir_victim_o.way = victim_way_i;

        // One-hot AND-OR muxes, zero when no way is selected
        for (int w = 0; w < `MEMCTRL_WAYS; w++) begin
            dir_hit_o.tag      |= rentries_i[w].tag & {`MEMCTRL_TAG_W{hit_way[w]}};
            dir_hit_o.dirty    |= rentries_i[w].dirty & hit_way[w];
            dir_victim_o.tag   |= rentries_i[w].tag & {`MEMCTRL_TAG_W{victim_way_i[w]}};
            dir_victim_o.valid |= rentries_i[w].valid & victim_way_i[w];
            dir_victim_o.dirty |= rentries_i[w].dirty & victim_way_i[w];
        end
    end

    // A tag lives in at most one way of a set
    always_comb begin
        if (!$isunknown(hit_way)) begin
            a_hit_onehot0: assert #0 ($onehot0(hit_way))
                else $error("memctrl_hit: tag hits in several ways, way=%h", hit_way);
        end
    end

endmodule

`default_nettype wire

// ==== source/memctrl_victim_sel.sv ====
// Victim selection: lowest invalid way, else per-set round-robin pointer
`timescale 1ns/1ps
`default_nettype none

`include "memctrl_params.svh"

module memctrl_victim_sel (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  memctrl_pkg::set_t     lookup_set_i,
    input  memctrl_pkg::way_vec_t valid_i,
    input  logic                  refill_i,
    input  memctrl_pkg::set_t     refill_set_i,
    input  memctrl_pkg::way_vec_t refill_way_i,
    output memctrl_pkg::way_vec_t victim_way_o
);
    import memctrl_pkg::*;

    way_vec_t rr_ptr_q [`MEMCTRL_SETS];
    way_vec_t next_ptr;
    way_vec_t first_inval;

    // Way after the refilled one, wrapping to way 0
    assign next_ptr = {refill_way_i[`MEMCTRL_WAYS-2:0], refill_way_i[`MEMCTRL_WAYS-1]};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int s = 0; s < `MEMCTRL_SETS; s++) begin
                rr_ptr_q[s] <= way_vec_t'(1);
            end
        end else if (refill_i) begin
            rr_ptr_q[refill_set_i] <= next_ptr;
        end
    end

    // Isolate lowest set bit of the invalid mask, x & -x with x = ~valid
    assign first_inval = ~valid_i & way_vec_t'(valid_i + 1'b1);

    assign victim_way_o = (&valid_i) ? rr_ptr_q[lookup_set_i] : first_inval;

    a_victim_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(valid_i) && !$isunknown(lookup_set_i) |-> $onehot(victim_way_o))
        else $error("memctrl_victim_sel: victim way %h is not one-hot", victim_way_o);

endmodule

`default_nettype wire

// ==== source/memctrl_data.sv ====
// Cache data array: write mux, per-way byte-lane RAMs and hit-way read select
`timescale 1ns/1ps
`default_nettype none

`include "memctrl_params.svh"

module memctrl_data (
    input  logic                   clk_i,
    input  memctrl_pkg::data_req_t data_req_i,
    input  memctrl_pkg::way_vec_t  hit_way_i,
    output memctrl_pkg::data_word_t data_rdata_o
);
    import memctrl_pkg::*;

    localparam int unsigned LANES = `MEMCTRL_WORD_W / 8;
    localparam int unsigned DEPTH = `MEMCTRL_SETS * `MEMCTRL_LINE_WORDS;

    typedef logic [$clog2(DEPTH)-1:0] data_addr_t;

    data_addr_t                         ram_addr;
    logic                               rd_en;
    logic                               wr_en;
    way_vec_t                           wr_way;
    byte_en_t                           wr_be;
    data_word_t [`MEMCTRL_WAYS-1:0]     way_rdata;

    // Line words are contiguous per set
    assign ram_addr = data_addr_t'(data_req_i.set) * data_addr_t'(`MEMCTRL_LINE_WORDS)
                    + data_addr_t'(data_req_i.word);

    always_comb begin
        rd_en  = 1'b0;
        wr_en  = 1'b0;
        wr_way = hit_way_i;
        wr_be  = data_req_i.be;

        case (data_req_i.op)
            DATA_READ: begin
                rd_en = 1'b1;
            end
            DATA_WRITE: begin
                wr_en = 1'b1;
            end
            // Refill writes the full word into the given way
            DATA_REFILL: begin
                wr_en  = 1'b1;
                wr_way = data_req_i.way;
                wr_be  = '1;
            end
            default: begin
            end
        endcase
    end

    for (genvar w = 0; w < `MEMCTRL_WAYS; w++) begin : g_way
        for (genvar b = 0; b < LANES; b++) begin : g_lane
            logic byte_we;

            assign byte_we = wr_en & wr_way[w] & wr_be[b];

            memctrl_sram #(
                .payload_t (logic [7:0]),
                .DEPTH     (DEPTH)
            ) u_data_ram (
                .clk_i,
                .cs_i      (rd_en | byte_we),
                .we_i      (byte_we),
                .addr_i    (ram_addr),
                .wdata_i   (data_req_i.wdata[8*b +: 8]),
                .rdata_o   (way_rdata[w][8*b +: 8])
            );
        end
    end

    // Hit way of the lookup issued with the read picks the word
    always_comb begin
        data_rdata_o = '0;
        for (int w = 0; w < `MEMCTRL_WAYS; w++) begin
            data_rdata_o |= way_rdata[w] & {`MEMCTRL_WORD_W{hit_way_i[w]}};
        end
    end

    a_write_needs_hit: assert property (@(posedge clk_i)
        data_req_i.op == DATA_WRITE |-> $onehot(hit_way_i))
        else $error("memctrl_data: write without a single hit way, way=%h", hit_way_i);

endmodule

`default_nettype wire

// ==== source/memctrl_top.sv ====
// Cache directory and data RAM controller top level
`timescale 1ns/1ps
`default_nettype none

`include "memctrl_params.svh"

module memctrl_top (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  memctrl_pkg::dir_req_t    dir_req_i,
    input  memctrl_pkg::data_req_t   data_req_i,
    output logic                     ready_o,
    output memctrl_pkg::dir_hit_t    dir_hit_o,
    output memctrl_pkg::dir_victim_t dir_victim_o,
    output memctrl_pkg::data_word_t  data_rdata_o
);
    import memctrl_pkg::*;

    dir_entry_t [`MEMCTRL_WAYS-1:0] rentries;
    tag_t                           lookup_tag;
    set_t                           lookup_set;
    way_vec_t                       dir_valid;
    way_vec_t                       victim_way;

    memctrl_dir u_dir (
        .clk_i,
        .rst_ni,
        .dir_req_i,
        .ready_o,
        .rentries_o   (rentries),
        .lookup_tag_o (lookup_tag),
        .lookup_set_o (lookup_set)
    );

    // Valid bits of the looked-up set
    for (genvar w = 0; w < `MEMCTRL_WAYS; w++) begin : g_valid
        assign dir_valid[w] = rentries[w].valid;
    end

    memctrl_victim_sel u_victim_sel (
        .clk_i,
        .rst_ni,
        .lookup_set_i (lookup_set),
        .valid_i      (dir_valid),
        .refill_i     (dir_req_i.op == DIR_REFILL),
        .refill_set_i (dir_req_i.set),
        .refill_way_i (dir_req_i.way),
        .victim_way_o (victim_way)
    );

    memctrl_hit u_hit (
        .rentries_i   (rentries),
        .lookup_tag_i (lookup_tag),
        .victim_way_i (victim_way),
        .dir_hit_o,
        .dir_victim_o
    );

    memctrl_data u_data (
        .clk_i,
        .data_req_i,
        .hit_way_i    (dir_hit_o.way),
        .data_rdata_o
    );

endmodule

`default_nettype wire

// ==== tb/tb_clk_gen.sv ====
// Testbench clock and reset source for the cache controller
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD_NS  = 40,
    parameter int RST_CYCLES = 8
) (
    output logic clk_o,
    output logic rst_no
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    // Release lands just after a rising edge, like the other inputs
    initial begin
        rst_no = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #2 rst_no = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb/memctrl_tb.sv ====
// Testbench for the cache directory and data RAM controller
`timescale 1ns/1ps
`default_nettype none

`include "memctrl_params.svh"

module memctrl_tb;
    import memctrl_pkg::*;

    localparam int WAYS        = `MEMCTRL_WAYS;
    localparam int SETS        = `MEMCTRL_SETS;
    localparam int LINE        = `MEMCTRL_LINE_WORDS;
    localparam int LANES       = `MEMCTRL_WORD_W / 8;
    localparam int WAY_BITS    = $clog2(`MEMCTRL_WAYS);
    localparam int DRIVE_DELAY = 2;
    localparam int TIMEOUT     = 200;

    logic        clk;
    logic        rst_n;
    dir_req_t    dir_req;
    data_req_t   data_req;
    logic        ready;
    dir_hit_t    dir_hit;
    dir_victim_t dir_victim;
    data_word_t  data_rdata;

    // Reference model of directory, pointers and data
    dir_entry_t  m_dir [SETS][WAYS];
    int          m_ptr [SETS];
    data_word_t  m_data [WAYS][SETS*LINE];
    way_vec_t    m_hit_way;

    dir_hit_t    exp_hit;
    dir_victim_t exp_victim;
    data_word_t  exp_rdata;
    logic        chk_dir;
    logic        chk_data;
    int          rst_cycles;
    logic [15:0] lfsr_q;

    int err_ready  = 0;
    int err_hit    = 0;
    int err_victim = 0;
    int err_rdata  = 0;

    tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(8)) u_clk_gen (
        .clk_o  (clk),
        .rst_no (rst_n)
    );

    memctrl_top u_dut (
        .clk_i        (clk),
        .rst_ni       (rst_n),
        .dir_req_i    (dir_req),
        .data_req_i   (data_req),
        .ready_o      (ready),
        .dir_hit_o    (dir_hit),
        .dir_victim_o (dir_victim),
        .data_rdata_o (data_rdata)
    );

    // Saturating count of cycles since reset release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rst_cycles <= 0;
        end else if (rst_cycles <= SETS) begin
            rst_cycles <= rst_cycles + 1;
        end
    end

    a_ready: assert property (@(posedge clk) disable iff (!rst_n)
        ready == (rst_cycles >= SETS))
        else begin
            err_ready++;
            $display("[ERROR] ready_o: got %h expected %h",
                     $sampled(ready), $sampled(rst_cycles) >= SETS);
        end

    a_hit: assert property (@(posedge clk) disable iff (!rst_n)
        chk_dir |-> dir_hit == exp_hit)
        else begin
            err_hit++;
            $display("[ERROR] dir_hit_o: got %h expected %h",
                     $sampled(dir_hit), $sampled(exp_hit));
        end

    a_victim: assert property (@(posedge clk) disable iff (!rst_n)
        chk_dir |-> dir_victim == exp_victim)
        else begin
            err_victim++;
            $display("[ERROR] dir_victim_o: got %h expected %h",
                     $sampled(dir_victim), $sampled(exp_victim));
        end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
        chk_data |-> data_rdata == exp_rdata)
        else begin
            err_rdata++;
            $display("[ERROR] data_rdata_o: got %h expected %h",
                     $sampled(data_rdata), $sampled(exp_rdata));
        end

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    // First invalid way or else the set's pointer
    function automatic int model_victim(input set_t set);
        for (int w = 0; w < WAYS; w++) begin
            if (!m_dir[set][w].valid) begin
                return w;
            end
        end
        return m_ptr[set];
    endfunction

    // Wait for the next edge and idle the request ports at the drive point
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
        dir_req  = '0;
        data_req = '0;
    endtask

    task automatic wait_ready(output logic ok);
        int cycles;
        ok = 1'b0;
        cycles = 0;
        while (!rst_n && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (!rst_n) begin
            $display("Timed out waiting for the release of reset");
            return;
        end
        cycles = 0;
        while (!ready && cycles < TIMEOUT) begin
            @(posedge clk);
            #DRIVE_DELAY;
            cycles++;
        end
        if (!ready) begin
            $display("Timed out waiting for ready_o after reset");
            return;
        end
        ok = 1'b1;
    endtask

    task automatic predict_lookup(input set_t set, input tag_t tag, input logic do_read,
                                  input word_idx_t word);
        int vic;
        exp_hit   = '0;
        exp_rdata = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (m_dir[set][w].valid && m_dir[set][w].tag == tag) begin
                exp_hit.way[w] = 1'b1;
                exp_hit.tag    = tag;
                exp_hit.dirty  = m_dir[set][w].dirty;
                exp_rdata      = m_data[w][int'(set) * LINE + int'(word)];
            end
        end
        vic = model_victim(set);
        exp_victim.way   = way_vec_t'(1) << vic;
        exp_victim.valid = m_dir[set][vic].valid;
        exp_victim.dirty = m_dir[set][vic].dirty;
        exp_victim.tag   = m_dir[set][vic].tag;
        m_hit_way = exp_hit.way;
        chk_dir   = 1'b1;
        chk_data  = do_read;
    endtask

    task automatic lookup(input set_t set, input tag_t tag, input logic do_read,
                          input word_idx_t word);
        dir_req.op        = DIR_LOOKUP;
        dir_req.set       = set;
        dir_req.entry.tag = tag;
        if (do_read) begin
            data_req.op   = DATA_READ;
            data_req.set  = set;
            data_req.word = word;
        end
        step();
        predict_lookup(set, tag, do_read, word);
    endtask

    // Directory refill rides with the first word of the line
    task automatic refill_line(input set_t set, input int way, input tag_t tag,
                               input logic dirty);
        logic [31:0] val;
        for (int i = 0; i < LINE; i++) begin
            take_bits(32, val);
            if (i == 0) begin
                dir_req.op          = DIR_REFILL;
                dir_req.set         = set;
                dir_req.way         = way_vec_t'(1) << way;
                dir_req.entry.valid = 1'b1;
                dir_req.entry.dirty = dirty;
                dir_req.entry.tag   = tag;
            end
            data_req.op    = DATA_REFILL;
            data_req.set   = set;
            data_req.word  = word_idx_t'(i);
            data_req.way   = way_vec_t'(1) << way;
            data_req.wdata = val;
            m_data[way][int'(set) * LINE + i] = val;
            step();
            if (i == 0) begin
                m_dir[set][way] = {1'b1, dirty, tag};
                m_ptr[set]      = (way + 1) % WAYS;
                chk_dir         = 1'b0;
            end
        end
    endtask

    task automatic invalidate(input set_t set, input int way);
        dir_req.op  = DIR_INVAL;
        dir_req.set = set;
        dir_req.way = way_vec_t'(1) << way;
        step();
        m_dir[set][way] = '0;
        chk_dir         = 1'b0;
    endtask

    // Lands in the hit way of the last lookup
    task automatic write_word(input set_t set, input word_idx_t word, input data_word_t wdata,
                              input byte_en_t be);
        int addr;
        addr = int'(set) * LINE + int'(word);
        data_req.op    = DATA_WRITE;
        data_req.set   = set;
        data_req.word  = word;
        data_req.wdata = wdata;
        data_req.be    = be;
        step();
        for (int w = 0; w < WAYS; w++) begin
            for (int b = 0; b < LANES; b++) begin
                if (m_hit_way[w] && be[b]) begin
                    m_data[w][addr][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
    endtask

    // Tag low bits hold the way so tags in a set never collide
    task automatic fill_next(input set_t set);
        logic [31:0] r;
        int          v;
        tag_t        tag;
        v = model_victim(set);
        take_bits(`MEMCTRL_TAG_W - WAY_BITS + 1, r);
        tag = (tag_t'(r[31:1]) << WAY_BITS) | tag_t'(v);
        lookup(set, tag, 1'b0, '0);
        refill_line(set, v, tag, r[0]);
        for (int i = 0; i < LINE; i++) begin
            lookup(set, tag, 1'b1, word_idx_t'(i));
        end
        lookup(set, tag ^ tag_t'(1 << (`MEMCTRL_TAG_W - 1)), 1'b1, '0);
    endtask

    task automatic read_set(input set_t set);
        for (int w = 0; w < WAYS; w++) begin
            for (int i = 0; i < LINE; i++) begin
                if (m_dir[set][w].valid) begin
                    lookup(set, m_dir[set][w].tag, 1'b1, word_idx_t'(i));
                end
            end
        end
    endtask

    task automatic run_tests();
        logic [31:0] r;
        logic [31:0] be;
        tag_t        old_tag;
        for (int s = 0; s < SETS; s++) begin
            take_bits(8, r);
            lookup(set_t'(s), tag_t'(r), 1'b1, word_idx_t'(s));
        end
        for (int k = 0; k < 3; k++) begin
            for (int i = 0; i < WAYS; i++) begin
                fill_next(set_t'(3 + 4 * k));
            end
        end
        // Partial write into way 1 of set 7
        lookup(set_t'(7), m_dir[7][1].tag, 1'b0, '0);
        take_bits(32, r);
        take_bits(4, be);
        // Lanes 0 and 3 differ so some bytes are kept
        be[0] = ~be[3];
        write_word(set_t'(7), word_idx_t'(2), r, byte_en_t'(be));
        read_set(set_t'(7));
        read_set(set_t'(3));
        old_tag = m_dir[7][2].tag;
        invalidate(set_t'(7), 2);
        lookup(set_t'(7), old_tag, 1'b1, '0);
        old_tag = m_dir[7][0].tag;
        invalidate(set_t'(7), 0);
        lookup(set_t'(7), old_tag, 1'b1, '0);
        fill_next(set_t'(7));
        fill_next(set_t'(7));
        // Victims of a full set walk the round-robin pointer
        for (int i = 0; i < 6; i++) begin
            fill_next(set_t'(11));
        end
        step();
        step();
    endtask

    initial begin
        logic ok;
        int   total;
        dir_req  = '0;
        data_req = '0;
        chk_dir  = 1'b0;
        chk_data = 1'b0;
        exp_hit    = '0;
        exp_victim = '0;
        exp_rdata  = '0;
        m_hit_way  = '0;
        lfsr_q     = 16'd49660;
        for (int s = 0; s < SETS; s++) begin
            m_ptr[s] = 0;
            for (int w = 0; w < WAYS; w++) begin
                m_dir[s][w] = '0;
            end
        end
        wait_ready(ok);
        if (ok) begin
            run_tests();
        end
        total = err_ready + err_hit + err_victim + err_rdata;
        $display("Errors: ready %0d, hit %0d, victim %0d, rdata %0d",
                 err_ready, err_hit, err_victim, err_rdata);
        if (ok && total == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+source
source/memctrl_pkg.sv
source/memctrl_sram.sv
source/memctrl_dir.sv
source/memctrl_hit.sv
source/memctrl_victim_sel.sv
source/memctrl_data.sv
source/memctrl_top.sv
tb/tb_clk_gen.sv
tb/memctrl_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= memctrl_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard source/*.sv source/*.svh tb/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "TEST PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
